// File: common/fib_pkg.sv
/*
 * FIB packet formats and table geometry
 * Prefix word, metadata byte and the prefix hash shared by the FIB blocks
 */
`default_nettype none

package fib_pkg;

    // Prefix word geometry
    localparam int PREFIX_W     = 64;
    localparam int PREFIX_BYTES = 8;

    // Length index and hash widths
    localparam int LEN_W  = 6;
    localparam int HASH_W = 6;

    // One table row per prefix length
    localparam int TABLE_ROWS = 64;

    // Metadata byte as it arrives on the wire, bit 7 down to bit 0
    typedef struct packed {
        logic             spare;
        logic             is_interest;
        logic [LEN_W-1:0] prefix_len;
    } metadata_s;

    // Prefix word, filled byte-wise on ingress and masked bit-wise during search
    // bytes[PREFIX_BYTES-1] is the most significant byte
    typedef union packed {
        logic [PREFIX_BYTES-1:0][7:0] bytes;
        logic [PREFIX_W-1:0]          bits;
    } prefix_word_u;

    // XOR fold of the prefix down to the hash width
    // Hash bit k collects every prefix bit whose index modulo HASH_W is k
    function automatic logic [HASH_W-1:0] prefix_hash(input prefix_word_u prefix);
        logic [HASH_W-1:0] h;
        h = '0;
        for (int i = 0; i < PREFIX_W; i++) begin
            h[i % HASH_W] = h[i % HASH_W] ^ prefix.bits[i];
        end
        return h;
    endfunction

endpackage

`default_nettype wire

// File: common/link_pkg.sv
/*
 * Link bundles around the FIB
 * SPI receive and transmit, PIT requests, lookups and the internal store links
 */
`default_nettype none

package link_pkg;

    import fib_pkg::*;

    // SPI receive side, start strobe then bytes
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } spi_rx_s;

    // SPI transmit side, frame flag then bytes
    typedef struct packed {
        logic       flag;
        logic [7:0] data;
    } spi_tx_s;

    // Parsed interest towards the PIT hash table
    typedef struct packed {
        logic         ready;
        metadata_s    metadata;
        prefix_word_u prefix;
    } pit_req_s;

    // Lookup request from the PIT
    typedef struct packed {
        logic         start;
        metadata_s    metadata;
        prefix_word_u prefix;
    } lookup_req_s;

    // Table write request
    typedef struct packed {
        logic             en;
        logic [LEN_W-1:0] len;
        prefix_word_u     prefix;
    } learn_s;

    // Table read request
    typedef struct packed {
        logic             en;
        logic [LEN_W-1:0] len;
        prefix_word_u     prefix;
    } probe_s;

    // Search result for the transmitter
    typedef struct packed {
        logic         valid;
        metadata_s    metadata;
        prefix_word_u total_prefix;
        prefix_word_u longest_prefix;
    } match_s;

endpackage

`default_nettype wire

// File: design/interest_parser.sv
/*
 * Interest parser on the SPI receive link
 * Collects metadata and prefix bytes, then publishes to the PIT and learns the prefix
 */
`default_nettype none

module interest_parser
    import fib_pkg::*;
    import link_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  spi_rx_s  spi_rx,
    output pit_req_s pit_req,
    output learn_s   learn
);

    localparam int CNT_W = $clog2(PREFIX_BYTES);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_META,
        ST_PREFIX,
        ST_PUBLISH
    } state_e;

    state_e       state_q;
    logic [CNT_W-1:0] byte_cnt_q;

    // Packet being assembled
    metadata_s    meta_q;
    prefix_word_u prefix_q;

    logic publish;

    // Control FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= ST_IDLE;
            byte_cnt_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // Start strobe only counts here
                    if (spi_rx.valid) begin
                        state_q <= ST_META;
                    end
                end
                ST_META: begin
                    state_q    <= ST_PREFIX;
                    byte_cnt_q <= CNT_W'(PREFIX_BYTES - 1);
                end
                ST_PREFIX: begin
                    if (byte_cnt_q == '0) begin
                        state_q <= ST_PUBLISH;
                    end else begin
                        byte_cnt_q <= byte_cnt_q - 1'b1;
                    end
                end
                ST_PUBLISH: begin
                    // One cycle with the packet on the outputs
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Byte capture, prefix arrives MSB first
    always_ff @(posedge clk) begin
        if (state_q == ST_META) begin
            meta_q <= metadata_s'(spi_rx.data);
        end
        if (state_q == ST_PREFIX) begin
            prefix_q.bytes <= {prefix_q.bytes[PREFIX_BYTES-2:0], spi_rx.data};
        end
    end

    // Non-interest packets are consumed silently
    assign publish = (state_q == ST_PUBLISH) && meta_q.is_interest;

    assign pit_req.ready    = publish;
    assign pit_req.metadata = meta_q;
    assign pit_req.prefix   = prefix_q;

    // Learn at the row given by the prefix length
    assign learn.en     = publish;
    assign learn.len    = meta_q.prefix_len;
    assign learn.prefix = prefix_q;

    // Ready is a single pulse per packet
    a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        pit_req.ready |=> !pit_req.ready)
        else $error("pit_req.ready held for more than one cycle");

endmodule

`default_nettype wire

// File: design/fib_store.sv
/*
 * FIB valid-bit store
 * Row per prefix length, column per prefix hash, with a learn and a probe port
 */
`default_nettype none

module fib_store
    import fib_pkg::*;
    import link_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  learn_s learn,
    input  probe_s probe,
    output logic   hit
);

    localparam int COLS = 2 ** HASH_W;

    // Valid bits, cleared by reset
    logic [TABLE_ROWS-1:0][COLS-1:0] valid_bits_q;

    // Learn pipeline stage
    logic              learn_pend_q;
    logic [LEN_W-1:0]  learn_row_q;
    logic [HASH_W-1:0] learn_hash_q;

    // Probe pipeline stage
    logic              probe_pend_q;
    logic [LEN_W-1:0]  probe_row_q;
    logic [HASH_W-1:0] probe_hash_q;

    // Request flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            learn_pend_q <= 1'b0;
            probe_pend_q <= 1'b0;
        end else begin
            learn_pend_q <= learn.en;
            probe_pend_q <= probe.en;
        end
    end

    // Row and hash registered ahead of the table access
    always_ff @(posedge clk) begin
        if (learn.en) begin
            learn_row_q  <= learn.len;
            learn_hash_q <= prefix_hash(learn.prefix);
        end
        if (probe.en) begin
            probe_row_q  <= probe.len;
            probe_hash_q <= prefix_hash(probe.prefix);
        end
    end

    // Bits are only ever set
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_bits_q <= '0;
        end else if (learn_pend_q) begin
            valid_bits_q[learn_row_q][learn_hash_q] <= 1'b1;
        end
    end

    // Answer one cycle after the probe
    assign hit = probe_pend_q && valid_bits_q[probe_row_q][probe_hash_q];

    // A hit always belongs to the probe of the previous cycle
    a_hit_after_probe: assert property (@(posedge clk) disable iff (rst)
        hit |-> $past(probe.en))
        else $error("hit raised without a probe in the previous cycle");

endmodule

`default_nettype wire

// File: lookup/lpm_search.sv
/*
 * Longest-prefix-match search
 * Probes from the requested length downwards, masking one prefix bit per miss
 */
`default_nettype none

module lpm_search
    import fib_pkg::*;
    import link_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  lookup_req_s lookup,
    input  logic        hit,
    input  logic        busy,
    output probe_s      probe,
    output match_s      match
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PROBE,
        ST_EVAL
    } state_e;

    state_e           state_q;
    logic [LEN_W-1:0] len_q;

    // Request copies and the working prefix
    metadata_s    meta_q;
    prefix_word_u total_q;
    prefix_word_u work_q;

    logic accept;
    logic found;
    logic step;

    // Start only when idle and the transmitter is free
    assign accept = (state_q == ST_IDLE) && lookup.start && !busy;

    // Stop on a hit, or once length 0 has been probed
    assign found = (state_q == ST_EVAL) && (hit || len_q == '0);

    // Miss with length left, drop one bit and go again
    assign step = (state_q == ST_EVAL) && !hit && (len_q != '0);

    // Control FSM and length
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
            len_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        state_q <= ST_PROBE;
                        len_q   <= lookup.metadata.prefix_len;
                    end
                end
                ST_PROBE: begin
                    state_q <= ST_EVAL;
                end
                ST_EVAL: begin
                    if (found) begin
                        state_q <= ST_IDLE;
                    end else begin
                        state_q <= ST_PROBE;
                        len_q   <= len_q - 1'b1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Payload capture and masking
    always_ff @(posedge clk) begin
        if (accept) begin
            meta_q  <= lookup.metadata;
            total_q <= lookup.prefix;
            work_q  <= lookup.prefix;
        end else if (step) begin
            work_q.bits[len_q] <= 1'b0;
        end
    end

    // Probe request for the current length
    assign probe.en     = (state_q == ST_PROBE);
    assign probe.len    = len_q;
    assign probe.prefix = work_q;

    // Result, valid for the single cycle that ends the search
    assign match.valid          = found;
    assign match.metadata       = meta_q;
    assign match.total_prefix   = total_q;
    assign match.longest_prefix = work_q;

    // Length 0 ends the search, never wraps
    a_no_len_wrap: assert property (@(posedge clk) disable iff (rst)
        ($past(state_q) != ST_IDLE && $past(len_q) == '0) |-> (len_q == '0))
        else $error("search length decremented below 0");

endmodule

`default_nettype wire

// File: lookup/tx_serializer.sv
/*
 * SPI transmit serializer
 * Flag cycle, then metadata, original prefix and matched prefix one byte at a time
 */
`default_nettype none

module tx_serializer
    import fib_pkg::*;
    import link_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  match_s  match,
    output logic    busy,
    output spi_tx_s spi_tx
);

    // Metadata plus two prefixes
    localparam int FRAME_BYTES = 1 + 2 * PREFIX_BYTES;
    localparam int CNT_W       = $clog2(FRAME_BYTES);

    // frame_q[FRAME_BYTES-1] goes out first
    logic [FRAME_BYTES-1:0][7:0] frame_q;

    logic             busy_q;
    logic             flag_q;
    logic [CNT_W-1:0] cnt_q;
    logic             sending;

    // Flag cycle first, then one byte per count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q <= 1'b0;
            flag_q <= 1'b0;
            cnt_q  <= '0;
        end else if (!busy_q) begin
            if (match.valid) begin
                busy_q <= 1'b1;
                flag_q <= 1'b1;
                cnt_q  <= '0;
            end
        end else if (flag_q) begin
            flag_q <= 1'b0;
        end else if (cnt_q == CNT_W'(FRAME_BYTES - 1)) begin
            // Last byte on the line this cycle
            busy_q <= 1'b0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Latch the whole result on acceptance
    always_ff @(posedge clk) begin
        if (match.valid && !busy_q) begin
            frame_q <= {match.metadata, match.total_prefix, match.longest_prefix};
        end
    end

    assign sending = busy_q && !flag_q;

    assign spi_tx.flag = flag_q;
    assign spi_tx.data = sending ? frame_q[CNT_W'(FRAME_BYTES - 1) - cnt_q] : 8'h00;

    // Search holds off while this is high
    assign busy = busy_q;

    // Search must not finish while a frame is still going out
    a_match_when_free: assert property (@(posedge clk) disable iff (rst)
        match.valid |-> !busy)
        else $error("match result arrived while transmitter busy");

endmodule

`default_nettype wire

// File: design/fib_table.sv
/*
 * FIB block of the NDN router, interest path only
 * Parser and search share one valid-bit store, results go out over SPI
 */
`default_nettype none

module fib_table
    import link_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  spi_rx_s     spi_rx,
    input  lookup_req_s lookup,
    output pit_req_s    pit_req,
    output spi_tx_s     spi_tx
);

    // Parser to store
    learn_s learn;

    // Search to store and back
    probe_s probe;
    logic   hit;

    // Search to transmitter and back
    match_s match;
    logic   busy;

    // Ingress side
    interest_parser u_interest_parser (
        .clk     (clk),
        .rst     (rst),
        .spi_rx  (spi_rx),
        .pit_req (pit_req),
        .learn   (learn)
    );

    // Valid bits per length and hash
    fib_store u_fib_store (
        .clk   (clk),
        .rst   (rst),
        .learn (learn),
        .probe (probe),
        .hit   (hit)
    );

    // Longest-prefix match
    lpm_search u_lpm_search (
        .clk    (clk),
        .rst    (rst),
        .lookup (lookup),
        .hit    (hit),
        .busy   (busy),
        .probe  (probe),
        .match  (match)
    );

    // Egress side
    tx_serializer u_tx_serializer (
        .clk    (clk),
        .rst    (rst),
        .match  (match),
        .busy   (busy),
        .spi_tx (spi_tx)
    );

endmodule

`default_nettype wire

// File: sim/fib_table_tb.sv
/*
 * Testbench for the FIB block
 * Random interest packets and lookups, checked against a table model
 */
`default_nettype none

module fib_table_tb
    import fib_pkg::*;
    import link_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FLAG_TIMEOUT = 300;
    localparam int MIX_OPS      = 200;
    localparam int FRAME_BYTES  = 17;

    logic        clk;
    logic        rst;
    spi_rx_s     spi_rx;
    lookup_req_s lookup;
    pit_req_s    pit_req;
    spi_tx_s     spi_tx;

    // Model table, row is the length, column the hash
    logic [63:0][63:0] model_table;

    // Prefixes that the model has learned, for lookups that hit
    logic [63:0] learned_prefix[$];
    logic [5:0]  learned_len[$];

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    fib_table u_fib_table (
        .clk     (clk),
        .rst     (rst),
        .spi_rx  (spi_rx),
        .lookup  (lookup),
        .pit_req (pit_req),
        .spi_tx  (spi_tx)
    );

    // Hash bit k folds prefix bits k, k+6, k+12 and so on
    function automatic logic [5:0] fold_hash(input logic [63:0] p);
        logic [5:0] h;
        h = '0;
        for (int k = 0; k < 6; k++) begin
            for (int i = k; i < 64; i += 6) begin
                h[k] ^= p[i];
            end
        end
        return h;
    endfunction

    // Expected matched prefix, walks the length down on every miss
    function automatic logic [63:0] model_search(input logic [63:0] p, input logic [5:0] len);
        logic [63:0] work;
        logic [5:0]  l;
        logic        done;
        work = p;
        l    = len;
        done = 1'b0;
        while (!done) begin
            if (model_table[l][fold_hash(work)] || l == 6'd0) begin
                done = 1'b1;
            end else begin
                work[l] = 1'b0;
                l       = l - 6'd1;
            end
        end
        return work;
    endfunction

    // Empty table result, bits len down to 1 cleared
    function automatic logic [63:0] cleared_bits(input logic [63:0] p, input logic [5:0] len);
        logic [63:0] r;
        r = p;
        for (int i = 1; i <= len; i++) begin
            r[i] = 1'b0;
        end
        return r;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // Stimulus and sampling point, 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Strobe, metadata byte, eight prefix bytes MSB first
    task automatic send_packet(input logic [7:0] meta, input logic [63:0] prefix);
        metadata_s   m;
        logic [71:0] frame;
        m     = metadata_s'(meta);
        frame = {meta, prefix};
        spi_rx.valid = 1'b1;
        spi_rx.data  = 8'h00;
        for (int i = 0; i < 9; i++) begin
            next_cycle();
            check_value("pit_req.ready", pit_req.ready, 1'b0);
            spi_rx.valid = 1'b0;
            spi_rx.data  = frame[71-8*i -: 8];
        end
        // Tenth cycle after the strobe
        next_cycle();
        spi_rx.data = 8'h00;
        check_value("pit_req.ready", pit_req.ready, m.is_interest);
        if (m.is_interest) begin
            check_value("pit_req.metadata", pit_req.metadata, meta);
            check_value("pit_req.prefix", pit_req.prefix, prefix);
            model_table[m.prefix_len][fold_hash(prefix)] = 1'b1;
            learned_prefix.push_back(prefix);
            learned_len.push_back(m.prefix_len);
        end
        // Single pulse, parser idle again
        next_cycle();
        check_value("pit_req.ready", pit_req.ready, 1'b0);
    endtask

    // Start pulse, bounded wait for the flag, then all 17 bytes
    task automatic run_lookup(input logic [7:0] meta, input logic [63:0] prefix,
                              input logic [63:0] exp_longest);
        logic [135:0] exp_frame;
        int           waited;
        exp_frame       = {meta, prefix, exp_longest};
        lookup.start    = 1'b1;
        lookup.metadata = metadata_s'(meta);
        lookup.prefix   = prefix;
        next_cycle();
        lookup.start = 1'b0;
        waited       = 0;
        while (spi_tx.flag !== 1'b1) begin
            if (waited >= FLAG_TIMEOUT) begin
                fail_run("Timeout, the SPI transmit flag never rose after a lookup");
            end
            next_cycle();
            waited++;
        end
        for (int i = 0; i < FRAME_BYTES; i++) begin
            next_cycle();
            check_value("spi_tx.flag", spi_tx.flag, 1'b0);
            check_value($sformatf("spi_tx.data byte %0d", i), spi_tx.data,
                        exp_frame[135-8*i -: 8]);
        end
        // Transmitter free from here on
        next_cycle();
        check_value("spi_tx.flag", spi_tx.flag, 1'b0);
    endtask

    initial begin
        logic [63:0] p;
        logic [7:0]  meta;
        logic [5:0]  len;
        logic        interest;
        int          pick;
        int          idx;
        void'($urandom(32'h0b5362de));
        model_table = '0;
        rst         = 1'b1;
        spi_rx      = '0;
        lookup      = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // Outputs quiet after reset
        check_value("spi_tx.flag", spi_tx.flag, 1'b0);
        check_value("pit_req.ready", pit_req.ready, 1'b0);
        next_cycle();

        // Empty table, each search runs down to length 0
        for (int n = 0; n < 5; n++) begin
            p = {$urandom, $urandom};
            if (n == 0) begin
                len = 6'd63;
            end else if (n == 1) begin
                len = 6'd0;
            end else begin
                len = 6'($urandom);
            end
            meta = {2'($urandom), len};
            run_lookup(meta, p, cleared_bits(p, len));
        end

        // Publish then exact hit at the learned length
        for (int n = 0; n < 8; n++) begin
            p    = {$urandom, $urandom};
            len  = 6'($urandom);
            meta = {1'($urandom), 1'b1, len};
            send_packet(meta, p);
            next_cycle();
            next_cycle();
            run_lookup(meta, p, p);
        end

        // Non-interest packets are dropped without learning
        for (int n = 0; n < 4; n++) begin
            p    = {$urandom, $urandom};
            len  = 6'($urandom);
            meta = {1'($urandom), 1'b0, len};
            send_packet(meta, p);
            next_cycle();
            next_cycle();
            run_lookup(meta, p, model_search(p, len));
        end

        // Random mix of packets and lookups
        for (int n = 0; n < MIX_OPS; n++) begin
            pick = $urandom_range(99, 0);
            if (pick < 45) begin
                p        = {$urandom, $urandom};
                len      = 6'($urandom);
                interest = ($urandom_range(9, 0) < 8);
                meta     = {1'($urandom), interest, len};
                send_packet(meta, p);
            end else begin
                if (pick < 70 && learned_prefix.size() > 0) begin
                    // Reuse a learned prefix, sometimes longer than learned
                    idx = $urandom_range(learned_prefix.size() - 1, 0);
                    p   = learned_prefix[idx];
                    len = learned_len[idx] + 6'($urandom_range(3, 0));
                end else begin
                    p   = {$urandom, $urandom};
                    len = 6'($urandom);
                end
                meta = {2'($urandom), len};
                next_cycle();
                next_cycle();
                run_lookup(meta, p, model_search(p, len));
            end
        end

        next_cycle();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: fib_table.f
common/fib_pkg.sv
common/link_pkg.sv
design/interest_parser.sv
design/fib_store.sv
lookup/lpm_search.sv
lookup/tx_serializer.sv
design/fib_table.sv
sim/fib_table_tb.sv
